// File: Bender.yml
package:
  name: fm_demod

sources:
  - src/fm_pkg.sv
  - src/sync_fifo.sv
  - src/divider.sv
  - src/qarctan.sv
  - src/demodulate.sv
  - src/fm_demod_top.sv
  - target: test
    files:
      - testbench/fm_demod_checker.sv
      - testbench/fm_demod_tb.sv

// File: all.f
src/fm_pkg.sv
src/sync_fifo.sv
src/divider.sv
src/qarctan.sv
src/demodulate.sv
src/fm_demod_top.sv
testbench/fm_demod_checker.sv
testbench/fm_demod_tb.sv

// File: src/demodulate.sv
// fm demodulate: conjugate product of successive samples, phase request, gain, output write.
`timescale 1ns/1ns

module demodulate import fm_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_empty,
    output logic                         in_rd_en,
    input  sample_t                      in_data,
    output logic                         arc_req,
    output sample_t                      arc_vec,
    input  logic                         arc_ack,
    input  logic signed [DATA_WIDTH-1:0] arc_angle,
    input  logic                         out_full,
    output logic                         out_wr_en,
    output logic signed [DATA_WIDTH-1:0] out_data
);

    demod_state_t state, state_c;
    logic    arc_req_c;
    sample_t prev, prev_c;                    // previous sample.
    sample_t cur, cur_c;                      // current sample.
    sample_t product;                         // conj of prev times cur.

    logic signed [DATA_WIDTH-1:0] p_rr;       // prev.re * cur.re.
    logic signed [DATA_WIDTH-1:0] p_ii;       // prev.im * cur.im.
    logic signed [DATA_WIDTH-1:0] p_ri;       // prev.re * cur.im.
    logic signed [DATA_WIDTH-1:0] p_ir;       // prev.im * cur.re.
    logic signed [DATA_WIDTH-1:0] gain_prod;

    // conjugate product, each term dequantized on its own.
    always_comb begin
        p_rr = prev.re * cur.re;
        p_ii = prev.im * cur.im;
        p_ri = prev.re * cur.im;
        p_ir = prev.im * cur.re;
        product.re = dequantize(p_rr) + dequantize(p_ii);
        product.im = dequantize(p_ri) - dequantize(p_ir);
    end

    assign gain_prod = arc_angle * DEMOD_GAIN;

    always_comb begin
        state_c   = state;
        arc_req_c = arc_req;
        prev_c    = prev;
        cur_c     = cur;
        in_rd_en  = 1'b0;
        out_wr_en = 1'b0;
        case (state)
            READ: begin
                if (!in_empty) begin
                    in_rd_en = 1'b1;              // pop head.
                    prev_c   = cur;               // shift sample history.
                    cur_c    = in_data;
                    state_c  = REQUEST;
                end
            end
            REQUEST: begin
                arc_req_c = 1'b1;                 // vector latches on this edge too.
                state_c   = WAIT_ACK;
            end
            WAIT_ACK: begin
                if (arc_ack) begin
                    arc_req_c = 1'b0;             // angle sampled.
                    state_c   = RELEASE;
                end
            end
            RELEASE: begin
                if (!arc_ack) state_c = OUTPUT;
            end
            OUTPUT: begin
                if (!out_full) begin
                    out_wr_en = 1'b1;             // held here under back-pressure.
                    state_c   = READ;
                end
            end
            default: state_c = READ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= READ;
            arc_req <= 1'b0;
            prev    <= '0;                        // first sample sees a zero history.
            cur     <= '0;
        end else begin
            state   <= state_c;
            arc_req <= arc_req_c;
            prev    <= prev_c;
            cur     <= cur_c;
        end
    end

    always_ff @(posedge clk) begin
        if (state == REQUEST) begin
            arc_vec <= product;                   // stable for the whole req phase.
        end
        if (state == WAIT_ACK && arc_ack) begin
            out_data <= dequantize(gain_prod);    // scaled phase, held until written.
        end
    end

endmodule

// File: src/divider.sv
// sequential restoring divider, signed dividend over positive divisor, four-phase req/ack.
`timescale 1ns/1ns

module divider import fm_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req,
    input  logic signed [DATA_WIDTH-1:0] dividend,
    input  logic signed [DATA_WIDTH-1:0] divisor,
    output logic                         ack,
    output logic signed [DATA_WIDTH-1:0] quotient
);

    logic                  busy;        // shift-subtract in progress.
    logic [5:0]            count;       // steps done, 32 means finish.
    logic                  start;
    logic [DATA_WIDTH-1:0] rem;         // partial remainder.
    logic [DATA_WIDTH-1:0] quo;         // dividend magnitude shifting out, quotient in.
    logic                  negate;      // dividend sign.
    logic [DATA_WIDTH-1:0] rem_shift;
    logic [DATA_WIDTH:0]   diff;        // extra bit is the borrow.

    // new request only once the last ack has gone.
    assign start = req && !busy && !ack;

    always_comb begin
        rem_shift = {rem[DATA_WIDTH-2:0], quo[DATA_WIDTH-1]};   // bring in next bit.
        diff      = {1'b0, rem_shift} - {1'b0, divisor};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
            ack   <= 1'b0;
        end else begin
            if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                if (count == 6'd32) begin
                    busy <= 1'b0;
                    ack  <= 1'b1;                // quotient valid from here.
                end else begin
                    count <= count + 1'b1;
                end
            end else if (ack && !req) begin
                ack <= 1'b0;                     // requester has sampled.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem    <= '0;
            quo    <= dividend[DATA_WIDTH-1] ? -dividend : dividend;   // magnitude.
            negate <= dividend[DATA_WIDTH-1];
        end else if (busy) begin
            if (count == 6'd32) begin
                quotient <= negate ? -quo : quo;     // sign back, truncates toward zero.
            end else if (!diff[DATA_WIDTH]) begin
                rem <= diff[DATA_WIDTH-1:0];         // subtract fits.
                quo <= {quo[DATA_WIDTH-2:0], 1'b1};
            end else begin
                rem <= rem_shift;                    // restore.
                quo <= {quo[DATA_WIDTH-2:0], 1'b0};
            end
        end
    end

endmodule

// File: src/fm_demod_top.sv
// fm demodulator top: input fifo, demodulate, qarctan, divider and output fifo.
`timescale 1ns/1ns

module fm_demod_top import fm_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_wr_en,
    input  sample_t                      in_data,
    output logic                         in_full,
    input  logic                         out_rd_en,
    output logic signed [DATA_WIDTH-1:0] out_data,
    output logic                         out_empty
);

    // input queue to demodulate.
    sample_t in_q_data;
    logic    in_q_empty;
    logic    in_q_rd_en;

    // demodulate to qarctan.
    logic                         arc_req;
    sample_t                      arc_vec;
    logic                         arc_ack;
    logic signed [DATA_WIDTH-1:0] arc_angle;

    // qarctan to divider.
    logic                         div_req;
    logic signed [DATA_WIDTH-1:0] div_dividend;
    logic signed [DATA_WIDTH-1:0] div_divisor;
    logic                         div_ack;
    logic signed [DATA_WIDTH-1:0] div_quotient;

    // demodulate to output queue.
    logic                         demod_wr_en;
    logic signed [DATA_WIDTH-1:0] demod_data;
    logic                         out_q_full;

    sync_fifo #(.WIDTH($bits(sample_t)), .DEPTH(FIFO_DEPTH)) in_fifo (
        .clk(clk), .reset(reset),
        .wr_en(in_wr_en), .wr_data(in_data), .full(in_full),
        .rd_en(in_q_rd_en), .rd_data(in_q_data), .empty(in_q_empty)
    );

    demodulate demod_inst (
        .clk(clk), .reset(reset),
        .in_empty(in_q_empty), .in_rd_en(in_q_rd_en), .in_data(in_q_data),
        .arc_req(arc_req), .arc_vec(arc_vec), .arc_ack(arc_ack), .arc_angle(arc_angle),
        .out_full(out_q_full), .out_wr_en(demod_wr_en), .out_data(demod_data)
    );

    qarctan arctan_inst (
        .clk(clk), .reset(reset),
        .req(arc_req), .vec(arc_vec), .ack(arc_ack), .angle(arc_angle),
        .div_req(div_req), .div_dividend(div_dividend), .div_divisor(div_divisor),
        .div_ack(div_ack), .div_quotient(div_quotient)
    );

    divider div_inst (
        .clk(clk), .reset(reset),
        .req(div_req), .dividend(div_dividend), .divisor(div_divisor),
        .ack(div_ack), .quotient(div_quotient)
    );

    sync_fifo #(.WIDTH(DATA_WIDTH), .DEPTH(FIFO_DEPTH)) out_fifo (
        .clk(clk), .reset(reset),
        .wr_en(demod_wr_en), .wr_data(demod_data), .full(out_q_full),
        .rd_en(out_rd_en), .rd_data(out_data), .empty(out_empty)
    );

endmodule

// File: src/fm_pkg.sv
// fm demodulator shared package: fixed-point constants, sample type, fsm states, dequantize.
package fm_pkg;

    // fixed-point format.
    localparam int QUANT_BITS = 10;           // fraction bits.
    localparam int DATA_WIDTH = 32;           // every data word.

    // arctangent constants, scaled by 2^QUANT_BITS.
    localparam logic signed [DATA_WIDTH-1:0] QUAD1 = 32'sd804;    // pi/4.
    localparam logic signed [DATA_WIDTH-1:0] QUAD3 = 32'sd2412;   // 3*pi/4.

    // output scale applied to the phase difference.
    localparam logic signed [DATA_WIDTH-1:0] DEMOD_GAIN = 32'sd758;

    // queue depth for input and output fifos.
    localparam int FIFO_DEPTH = 16;

    // one complex baseband sample.
    // re sits in the upper word, im in the lower.
    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] re;     // in-phase.
        logic signed [DATA_WIDTH-1:0] im;     // quadrature.
    } sample_t;

    // demodulate fsm.
    typedef enum logic [2:0] {
        READ,         // pop next sample.
        REQUEST,      // latch product, raise req.
        WAIT_ACK,     // angle in progress.
        RELEASE,      // wait for ack low.
        OUTPUT        // push scaled result.
    } demod_state_t;

    // qarctan fsm.
    typedef enum logic [2:0] {
        IDLE,         // wait for req.
        DIVIDE,       // divider busy.
        DIV_RELEASE,  // wait for div_ack low.
        ANGLE,        // form angle from quotient.
        DONE          // ack held until req drops.
    } arctan_state_t;

    // drop the fraction bits of a product.
    // arithmetic shift, so negatives round toward minus infinity.
    function automatic logic signed [DATA_WIDTH-1:0] dequantize(
        input logic signed [DATA_WIDTH-1:0] value
    );
        return value >>> QUANT_BITS;
    endfunction

endpackage

// File: src/qarctan.sv
// quadrant arctangent of a complex vector, one division per angle through the divider link.
`timescale 1ns/1ns

module qarctan import fm_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req,
    input  sample_t                      vec,
    output logic                         ack,
    output logic signed [DATA_WIDTH-1:0] angle,
    output logic                         div_req,
    output logic signed [DATA_WIDTH-1:0] div_dividend,
    output logic signed [DATA_WIDTH-1:0] div_divisor,
    input  logic                         div_ack,
    input  logic signed [DATA_WIDTH-1:0] div_quotient
);

    arctan_state_t state, state_c;
    logic ack_c;
    logic div_req_c;

    logic signed [DATA_WIDTH-1:0] abs_y;       // |im| + 1, never zero.
    logic signed [DATA_WIDTH-1:0] num;
    logic signed [DATA_WIDTH-1:0] den;
    logic signed [DATA_WIDTH-1:0] quo;         // latched quotient.
    logic signed [DATA_WIDTH-1:0] quo_prod;
    logic signed [DATA_WIDTH-1:0] base_angle;
    logic                         left_half;   // re below zero, QUAD3 branch.
    logic                         negate;      // im below zero, mirror result.

    // quotient operands from the input vector.
    always_comb begin
        abs_y = (vec.im < 0) ? -vec.im : vec.im;
        abs_y = abs_y + 1;
        if (vec.re >= 0) begin
            num = (vec.re - abs_y) <<< QUANT_BITS;
            den = vec.re + abs_y;
        end else begin
            num = (vec.re + abs_y) <<< QUANT_BITS;
            den = abs_y - vec.re;                   // still positive.
        end
    end

    // angle from quotient.
    always_comb begin
        quo_prod   = QUAD1 * quo;
        base_angle = (left_half ? QUAD3 : QUAD1) - dequantize(quo_prod);
    end

    always_comb begin
        state_c   = state;
        ack_c     = ack;
        div_req_c = div_req;
        case (state)
            IDLE: begin
                if (req) begin
                    div_req_c = 1'b1;              // operands latch on the same edge.
                    state_c   = DIVIDE;
                end
            end
            DIVIDE: begin
                if (div_ack) begin
                    div_req_c = 1'b0;
                    state_c   = DIV_RELEASE;
                end
            end
            DIV_RELEASE: begin
                if (!div_ack) state_c = ANGLE;     // divider free again.
            end
            ANGLE: begin
                ack_c   = 1'b1;
                state_c = DONE;
            end
            DONE: begin
                if (!req) begin
                    ack_c   = 1'b0;
                    state_c = IDLE;
                end
            end
            default: state_c = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            ack     <= 1'b0;
            div_req <= 1'b0;
        end else begin
            state   <= state_c;
            ack     <= ack_c;
            div_req <= div_req_c;
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (req) begin
                    div_dividend <= num;
                    div_divisor  <= den;
                    left_half    <= (vec.re < 0);
                    negate       <= (vec.im < 0);
                end
            end
            DIVIDE: if (div_ack) quo <= div_quotient;
            ANGLE: angle <= negate ? -base_angle : base_angle;
            default: ;
        endcase
    end

endmodule

// File: src/sync_fifo.sv
// synchronous first-word-fall-through fifo with pointer-derived full and empty flags.
`timescale 1ns/1ns

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty
);

    logic [WIDTH-1:0] mem [DEPTH];   // storage array.

    // pointers carry one wrap bit above the address.
    logic [$clog2(DEPTH):0] wr_ptr;
    logic [$clog2(DEPTH):0] rd_ptr;

    logic do_write;
    logic do_read;

    assign do_write = wr_en && !full;   // writes into a full queue are dropped.
    assign do_read  = rd_en && !empty;  // reads of an empty queue are ignored.

    // same address, same wrap: nothing stored.
    assign empty = (wr_ptr == rd_ptr);

    // same address, wrap bits differ: all entries used.
    assign full = (wr_ptr[$clog2(DEPTH)] != rd_ptr[$clog2(DEPTH)]) &&
                  (wr_ptr[$clog2(DEPTH)-1:0] == rd_ptr[$clog2(DEPTH)-1:0]);

    // head entry always visible.
    assign rd_data = mem[rd_ptr[$clog2(DEPTH)-1:0]];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;   // independent of write, so both may move.
            end
        end
    end

    // data array.
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[$clog2(DEPTH)-1:0]] <= wr_data;
        end
    end

endmodule

// File: testbench/fm_demod_checker.sv
// protocol checker for the qarctan req/ack links, bound into qarctan.
`timescale 1ns/1ns

module fm_demod_checker import fm_pkg::*; (
    input logic                         clk,
    input logic                         reset,
    input logic                         req,
    input logic                         ack,
    input logic                         div_req,
    input logic                         div_ack,
    input logic signed [DATA_WIDTH-1:0] div_dividend,
    input logic signed [DATA_WIDTH-1:0] div_divisor
);

    int unsigned error_count;   // assertion failures so far.

    initial error_count = 0;

    // requester keeps req up until the angle is ready.
    req_held: assert property (@(posedge clk) disable iff (reset) req && !ack |=> req)
        else begin
            $error("req dropped before ack");
            error_count++;
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
        else begin
            $error("ack raised without req");
            error_count++;
        end

    // divider operands frozen for the whole request.
    div_operands_stable: assert property (@(posedge clk) disable iff (reset)
        div_req && !div_ack |=> $stable(div_dividend) && $stable(div_divisor))
        else begin
            $error("divider operands changed under div_req");
            error_count++;
        end

    div_req_after_ack: assert property (@(posedge clk) disable iff (reset)
        $rose(div_req) |-> !div_ack)
        else begin
            $error("div_req raised while div_ack high");
            error_count++;
        end

endmodule

bind qarctan fm_demod_checker checks (
    .clk(clk), .reset(reset), .req(req), .ack(ack),
    .div_req(div_req), .div_ack(div_ack),
    .div_dividend(div_dividend), .div_divisor(div_divisor)
);

// File: testbench/fm_demod_tb.sv
// testbench for the fm demodulator: sample table, reference model, random read stalls.
`timescale 1ns/1ns

module fm_demod_tb import fm_pkg::*;;

    localparam int NUM_TESTS      = 16;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 60 + 200;   // worst latency per sample plus slack.
    localparam int FILL_CYCLES    = FIFO_DEPTH * 46;         // output fifo full before first read.

    logic                         clk;
    logic                         reset;
    logic                         in_wr_en;
    sample_t                      in_data;
    logic                         in_full;
    logic                         out_rd_en;
    logic signed [DATA_WIDTH-1:0] out_data;
    logic                         out_empty;

    sample_t                      stim [NUM_TESTS];       // input column.
    string                        names [NUM_TESTS];
    logic signed [DATA_WIDTH-1:0] expected [NUM_TESTS];   // model column.

    int     pass_count;
    int     fail_count;
    int     read_count;
    int     cycles;
    integer seed;

    fm_demod_top UUT (
        .clk(clk), .reset(reset),
        .in_wr_en(in_wr_en), .in_data(in_data), .in_full(in_full),
        .out_rd_en(out_rd_en), .out_data(out_data), .out_empty(out_empty)
    );

    always #2 clk = ~clk;   // 4 ns period.

    // drop fraction bits, floor for negatives.
    function automatic logic signed [DATA_WIDTH-1:0] drop_frac(
        input logic signed [DATA_WIDTH-1:0] v
    );
        return v >>> QUANT_BITS;
    endfunction

    // full chain: conjugate product, quadrant arctangent, gain.
    function automatic logic signed [DATA_WIDTH-1:0] model_output(
        input sample_t p,
        input sample_t c
    );
        logic signed [DATA_WIDTH-1:0] t1, t2, x, y, abs_y, num, den, q, qp, base, ang, g;
        t1 = p.re * c.re;
        t2 = p.im * c.im;
        x  = drop_frac(t1) + drop_frac(t2);
        t1 = p.re * c.im;
        t2 = p.im * c.re;
        y  = drop_frac(t1) - drop_frac(t2);
        abs_y = ((y < 0) ? -y : y) + 1;        // never zero.
        if (x >= 0) begin
            num = (x - abs_y) <<< QUANT_BITS;
            den = x + abs_y;
        end else begin
            num = (x + abs_y) <<< QUANT_BITS;
            den = abs_y - x;
        end
        q    = num / den;                      // truncates toward zero.
        qp   = QUAD1 * q;
        base = ((x < 0) ? QUAD3 : QUAD1) - drop_frac(qp);
        ang  = (y < 0) ? -base : base;
        g    = ang * DEMOD_GAIN;
        return drop_frac(g);
    endfunction

    task automatic set_entry(input int idx, input string name, input int re, input int im);
        names[idx]   = name;
        stim[idx].re = re;
        stim[idx].im = im;
    endtask

    task automatic load_table();
        sample_t prev;
        set_entry(0, "walk_0", 1024, 0);         // first one sees zero history.
        set_entry(1, "walk_45", 724, 724);
        set_entry(2, "walk_90", 0, 1024);
        set_entry(3, "walk_135", -724, 724);
        set_entry(4, "walk_180", -1024, 0);
        set_entry(5, "walk_225", -724, -724);
        set_entry(6, "walk_270", 0, -1024);
        set_entry(7, "walk_315", 724, -724);
        set_entry(8, "zero_a", 0, 0);
        set_entry(9, "zero_b", 0, 0);            // zero times zero.
        set_entry(10, "repeat_a", 512, 300);
        set_entry(11, "repeat_b", 512, 300);     // same vector, near zero angle.
        set_entry(12, "quad3_pos_im", -900, 200);
        set_entry(13, "quad3_neg_im", 800, 500); // turns back about 135 degrees.
        set_entry(14, "neg_im", 900, -400);      // turns back about 56 degrees.
        set_entry(15, "small_step", 1000, 50);
        prev = '0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            expected[i] = model_output(prev, stim[i]);
            prev = stim[i];
        end
    endtask

    task automatic check_value(input string name, input logic signed [DATA_WIDTH-1:0] exp_v,
                               input logic signed [DATA_WIDTH-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("Error %s: expected %0d, actual %0d", name, exp_v, act_v);
            fail_count++;
        end else begin
            $display("ok %s: %0d", name, act_v);
            pass_count++;
        end
    endtask

    task automatic write_samples();
        for (int i = 0; i < NUM_TESTS; i++) begin
            while (in_full) begin
                @(posedge clk);
                #1;                              // source waits on a full queue.
            end
            in_data  = stim[i];
            in_wr_en = 1'b1;
            @(posedge clk);
            #1;
        end
        in_wr_en = 1'b0;
    endtask

    // long stall first so the output queue fills, then pops with random idle gaps.
    task automatic read_results();
        int gap;
        gap = 0;
        repeat (FILL_CYCLES) @(posedge clk);
        while (read_count < NUM_TESTS) begin
            @(posedge clk);
            #1;
            out_rd_en = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (!out_empty) begin
                check_value(names[read_count], expected[read_count], out_data);
                read_count++;
                out_rd_en = 1'b1;
                gap = $random(seed) & 15;
            end
        end
        @(posedge clk);
        #1;
        out_rd_en = 1'b0;
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        in_wr_en   = 1'b0;
        in_data    = '0;
        out_rd_en  = 1'b0;
        pass_count = 0;
        fail_count = 0;
        read_count = 0;
        seed       = 46201;
        load_table();
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        if (out_empty !== 1'b1 || in_full !== 1'b0) begin
            $display("Error reset_state: expected out_empty 1 in_full 0, actual %b %b",
                     out_empty, in_full);
            fail_count++;
        end else begin
            $display("ok reset_state: out_empty high, in_full low");
            pass_count++;
        end
        fork
            write_samples();
            read_results();
        join
        repeat (60) @(posedge clk);              // room for a stray extra write.
        #1;
        if (!out_empty) begin
            $display("output_count: an extra result appeared after %0d outputs", read_count);
            fail_count++;
        end else begin
            $display("ok output_count: %0d outputs for %0d inputs", read_count, NUM_TESTS);
            pass_count++;
        end
        fail_count += UUT.arctan_inst.checks.error_count;
        $display("passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog.
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles, %0d results read",
                 cycles, read_count);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
